/* Makefile */
VERILATOR ?= verilator
TOP       ?= trace_dma_tb
FILELIST  ?= trace_dma.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) | tee $(LOG)

check: run
	@grep -qx '>>> PASS' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/trace_dma_asserts.sv */
`timescale 1ns/100ps

module trace_dma_asserts
  import trace_dma_pkg::*;
(
  input logic                  clk,
  input logic                  rst,
  input logic                  trace_valid,
  input logic [data_width-1:0] trace_data,
  input logic                  trace_ready,
  input logic [addr_width-1:0] m_axi_awaddr,
  input logic                  m_axi_awvalid,
  input logic                  m_axi_awready,
  input logic [data_width-1:0] m_axi_wdata,
  input logic                  m_axi_wvalid,
  input logic                  m_axi_wready
);

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
    else $error("awvalid dropped or awaddr changed before awready");

  w_hold: assert property (@(posedge clk) disable iff (rst)
    m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wdata))
    else $error("wvalid dropped or wdata changed before wready");

  // the producer keeps its word on the bus until the FIFO takes it.
  trace_hold: assert property (@(posedge clk) disable iff (rst)
    trace_valid && !trace_ready |=> trace_valid && $stable(trace_data))
    else $error("trace word changed while stalled");

  reset_quiet: assert property (@(posedge clk) rst |=> !m_axi_awvalid && !m_axi_wvalid)
    else $error("write channel valid high right after reset");

endmodule

/* bench/trace_dma_tb.sv */
`timescale 1ns/100ps

module trace_dma_tb
  import trace_dma_pkg::*;
();

  localparam int max_cycles = 20000;
  localparam logic [addr_width-1:0] region_base = 36'h8_0000_1000;

  logic clk, rst, ctrl_wen, ctrl_ren, trace_valid, trace_ready, trace_full;
  logic [ctrl_addr_width-1:0] ctrl_waddr, ctrl_raddr;
  logic [31:0] ctrl_wdata, ctrl_rdata;
  logic [data_width-1:0] trace_data, m_axi_wdata;
  logic [addr_width-1:0] m_axi_awaddr;
  logic m_axi_awvalid, m_axi_awready, m_axi_wvalid, m_axi_wready, m_axi_bvalid;
  logic [1:0] m_axi_bresp;

  logic [data_width-1:0] mem [logic [addr_width-1:0]];
  logic [addr_width-1:0] aw_q[$], wr_addr_q[$], err_addrs[$];
  logic [data_width-1:0] w_q[$], wr_data_q[$], sent_q[$];
  logic [addr_width-1:0] aw_addr, pair_addr;
  logic [data_width-1:0] w_data, pair_data;
  logic aw_take, w_take, rand_ready;
  int aw_stall = 0;
  int w_stall = 0;
  int cycles = 0;

  trace_dma i_trace_dma (.*);

  bind trace_dma trace_dma_asserts i_asserts (
    .clk, .rst, .trace_valid, .trace_data, .trace_ready, .m_axi_awaddr, .m_axi_awvalid,
    .m_axi_awready, .m_axi_wdata, .m_axi_wvalid, .m_axi_wready
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
      $display(">>> FAIL");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic compare(input logic [63:0] expected, input logic [63:0] actual,
                         input string what);
    if (expected !== actual) begin
      $display("Mismatch at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  function automatic bit is_error_addr(input logic [addr_width-1:0] addr);
    foreach (err_addrs[i]) begin
      if (err_addrs[i] == addr) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic pick_ready(inout int stall, output logic ready);
    if (stall > 0) begin
      ready = 1'b0;
      stall--;
    end else begin
      ready = 1'b1;
      stall = rand_ready ? int'($urandom_range(3, 0)) : 0; // low for 0 to 3 cycles.
    end
  endtask

  // the slave side samples handshakes at the falling edge and drives responses after the rise.
  initial begin
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    m_axi_bvalid  = 1'b0;
    m_axi_bresp   = 2'd0;
    forever begin
      @(negedge clk);
      aw_take = m_axi_awvalid && m_axi_awready;
      w_take  = m_axi_wvalid && m_axi_wready;
      aw_addr = m_axi_awaddr;
      w_data  = m_axi_wdata;
      @(posedge clk);
      #1;
      if (aw_take) aw_q.push_back(aw_addr);
      if (w_take) w_q.push_back(w_data);
      m_axi_bvalid = 1'b0;
      if ((aw_q.size() > 0) && (w_q.size() > 0)) begin
        pair_addr = aw_q.pop_front();
        pair_data = w_q.pop_front();
        mem[pair_addr] = pair_data;
        wr_addr_q.push_back(pair_addr);
        wr_data_q.push_back(pair_data);
        m_axi_bvalid = 1'b1;
        m_axi_bresp  = is_error_addr(pair_addr) ? 2'b10 : 2'b00; // slverr on listed addresses.
      end
      pick_ready(aw_stall, m_axi_awready);
      pick_ready(w_stall, m_axi_wready);
    end
  end

  task automatic reg_write(input logic [ctrl_addr_width-1:0] addr, input logic [31:0] data);
    ctrl_wen   = 1'b1;
    ctrl_waddr = addr;
    ctrl_wdata = data;
    @(posedge clk);
    #1;
    ctrl_wen = 1'b0;
  endtask

  task automatic reg_read(input logic [ctrl_addr_width-1:0] addr, output logic [31:0] data);
    ctrl_ren   = 1'b1;
    ctrl_raddr = addr;
    @(posedge clk);
    #1;
    ctrl_ren = 1'b0;
    data     = ctrl_rdata;
  endtask

  task automatic read_expect(input logic [ctrl_addr_width-1:0] addr, input logic [31:0] expected,
                             input string what);
    logic [31:0] value;
    reg_read(addr, value);
    compare(64'(expected), 64'(value), what);
  endtask

  task automatic send_words(input int count);
    logic [data_width-1:0] word;
    int i;
    for (i = 0; i < count; i++) begin
      word        = {$urandom, $urandom};
      trace_valid = 1'b1;
      trace_data  = word;
      @(negedge clk);
      while (!trace_ready) @(negedge clk);
      @(posedge clk);
      #1;
      sent_q.push_back(word);
    end
    trace_valid = 1'b0;
  endtask

  task automatic wait_writes(input int count);
    while (wr_addr_q.size() < count) begin
      @(posedge clk);
      #1;
    end
    repeat (3) @(posedge clk); // lets the last response reach the error counter.
    #1;
    compare(64'(count), 64'(wr_addr_q.size()), "number of writes");
  endtask

  task automatic check_writes(input int first, input int count, input int region,
                              input int start);
    logic [addr_width-1:0] addr;
    int i;
    for (i = 0; i < count; i++) begin
      addr = region_base + addr_width'((start + beat_bytes * i) % region);
      compare(64'(addr), 64'(wr_addr_q[first + i]), "write address");
      compare(sent_q[first + i], wr_data_q[first + i], "write data");
    end
  endtask

  // the last pass over the region leaves its words in memory.
  task automatic verify_memory(input int count, input int region, input int start);
    logic [addr_width-1:0] addr;
    int i;
    for (i = count - region / beat_bytes; i < count; i++) begin
      addr = region_base + addr_width'((start + beat_bytes * i) % region);
      compare(sent_q[i], mem[addr], "memory contents");
    end
  endtask

  task automatic clear_records();
    sent_q.delete();
    wr_addr_q.delete();
    wr_data_q.delete();
  endtask

  task automatic regs_readback();
    read_expect(reg_mode, 0, "mode after reset");
    read_expect(reg_base_lo, 0, "base_lo after reset");
    read_expect(reg_base_hi, 0, "base_hi after reset");
    read_expect(reg_size, 0, "size after reset");
    read_expect(reg_offset, 0, "offset after reset");
    read_expect(reg_full, 0, "full after reset");
    read_expect(reg_errors, 0, "errors after reset");
    reg_write(reg_mode, 32'hffff_fffd);
    reg_write(reg_base_lo, 32'h1234_5678);
    reg_write(reg_base_hi, 32'hffff_fffa);
    reg_write(reg_size, 32'h5a5a_5a53);
    reg_write(reg_offset, 32'h0000_0120);
    reg_write(reg_full, 32'h1);
    reg_write(reg_errors, 32'hffff_ffff);
    read_expect(reg_mode, 32'h1, "mode readback");
    read_expect(reg_base_lo, 32'h1234_5678, "base_lo readback");
    read_expect(reg_base_hi, 32'ha, "base_hi readback");
    read_expect(reg_size, 32'h3, "size readback");
    read_expect(reg_offset, 32'h120, "offset readback");
    read_expect(reg_full, 32'h1, "full readback");
    read_expect(reg_errors, 32'h0, "errors readback");
    read_expect(12'h100, 32'h0, "unmapped offset");
    reg_write(reg_full, 32'h0);
  endtask

  task automatic wrap_capture();
    reg_write(reg_base_lo, region_base[31:0]);
    reg_write(reg_base_hi, 32'(region_base[addr_width-1:32]));
    reg_write(reg_size, 32'h0);
    reg_write(reg_mode, 32'h1);
    reg_write(reg_offset, 32'd16);
    clear_records();
    send_words(20);
    wait_writes(20);
    check_writes(0, 20, 64, 16);
    verify_memory(20, 64, 16);
    compare(0, 64'(trace_full), "trace_full in wrap mode");
    read_expect(reg_offset, (16 + 20 * beat_bytes) % 64, "offset after wrap");
  endtask

  task automatic stop_capture();
    reg_write(reg_mode, 32'h0);
    reg_write(reg_offset, 32'h0);
    clear_records();
    send_words(16); // eight fill the region and eight fill the FIFO.
    while (!trace_full) begin
      @(posedge clk);
      #1;
    end
    repeat (4) @(posedge clk);
    #1;
    compare(8, 64'(wr_addr_q.size()), "writes before stop");
    check_writes(0, 8, 64, 0);
    read_expect(reg_full, 32'h1, "full flag after stop");
    read_expect(reg_offset, 32'd64, "offset at region end");
    @(negedge clk);
    compare(0, 64'(trace_ready), "trace_ready with a full FIFO");
    @(posedge clk);
    #1;
    reg_write(reg_full, 32'h0);
    reg_write(reg_offset, 32'h0);
    wait_writes(16);
    check_writes(8, 8, 64, 0);
    while (!trace_full) begin
      @(posedge clk);
      #1;
    end
    reg_write(reg_full, 32'h0);
    reg_write(reg_offset, 32'h0);
  endtask

  task automatic random_stall_capture();
    reg_write(reg_mode, 32'h1);
    reg_write(reg_size, 32'h2);
    reg_write(reg_offset, 32'h0);
    rand_ready = 1'b1;
    clear_records();
    send_words(100);
    wait_writes(100);
    check_writes(0, 100, 256, 0);
    verify_memory(100, 256, 0);
    rand_ready = 1'b0;
  endtask

  task automatic error_count();
    reg_write(reg_offset, 32'h0);
    reg_write(reg_errors, 32'h0);
    err_addrs = '{region_base + 36'd16, region_base + 36'd40, region_base + 36'd64};
    clear_records();
    send_words(10);
    wait_writes(10);
    check_writes(0, 10, 256, 0);
    read_expect(reg_errors, 32'd3, "error count");
    reg_write(reg_errors, 32'h0);
    read_expect(reg_errors, 32'd0, "error count after clear");
    err_addrs.delete();
  endtask

  initial begin
    void'($urandom(32'hcfed));
    rst         = 1'b1;
    ctrl_wen    = 1'b0;
    ctrl_waddr  = '0;
    ctrl_wdata  = '0;
    ctrl_ren    = 1'b0;
    ctrl_raddr  = '0;
    trace_valid = 1'b0;
    trace_data  = '0;
    rand_ready  = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    regs_readback();
    wrap_capture();
    stop_capture();
    random_stall_capture();
    error_count();
    $display(">>> PASS");
    $finish;
  end

endmodule

/* trace_dma.f */
verilog/trace_dma_pkg.sv
verilog/trace_regs.sv
verilog/trace_fifo.sv
verilog/trace_axi_writer.sv
verilog/trace_dma.sv
bench/trace_dma_asserts.sv
bench/trace_dma_tb.sv

/* verilog/trace_axi_writer.sv */
`timescale 1ns/100ps

module trace_axi_writer
  import trace_dma_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  write_mode_e           mode,
  input  logic [addr_width-1:0] base_addr,
  input  logic [3:0]            size_field,
  input  logic                  offset_load,
  input  logic [31:0]           offset_value,
  input  logic                  full,
  input  logic                  fifo_valid,
  input  logic [data_width-1:0] fifo_data,
  output logic                  fifo_ready,
  output logic [addr_width-1:0] m_axi_awaddr,
  output logic                  m_axi_awvalid,
  input  logic                  m_axi_awready,
  output logic [data_width-1:0] m_axi_wdata,
  output logic                  m_axi_wvalid,
  input  logic                  m_axi_wready,
  input  logic [1:0]            m_axi_bresp,
  input  logic                  m_axi_bvalid,
  output logic [31:0]           write_offset,
  output logic                  full_set,
  output logic                  resp_error
);

  writer_state_e         state;
  logic [31:0]           offset;
  logic [31:0]           next_offset;
  logic [31:0]           region_end;
  logic                  at_end;
  logic                  aw_done;
  logic                  w_done;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  write_done;
  logic [data_width-1:0] word;
  logic [addr_width-1:0] addr_q;

  assign region_end  = 32'(region_unit) << size_field;
  assign next_offset = offset + 32'(beat_bytes);
  assign at_end      = (mode == mode_stop) && (offset >= region_end);

  assign aw_hs      = m_axi_awvalid && m_axi_awready;
  assign w_hs       = m_axi_wvalid && m_axi_wready;
  assign write_done = (aw_done || aw_hs) && (w_done || w_hs); // channels may finish in any order.

  assign fifo_ready    = (state == st_idle) && !full && !at_end;
  assign m_axi_awvalid = (state == st_issue) && !aw_done;
  assign m_axi_wvalid  = (state == st_issue) && !w_done;
  assign m_axi_awaddr  = addr_q;
  assign m_axi_wdata   = word;
  assign write_offset  = offset;
  assign resp_error    = m_axi_bvalid && (m_axi_bresp != axi_resp_okay);

  // address and data are captured at the pop so they hold while a channel waits.
  always_ff @(posedge clk) begin
    if (fifo_valid && fifo_ready) begin
      word   <= fifo_data;
      addr_q <= base_addr + addr_width'(offset);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      offset   <= '0;
      aw_done  <= 1'b0;
      w_done   <= 1'b0;
      full_set <= 1'b0;
    end else begin
      full_set <= 1'b0;
      if (offset_load) begin
        offset <= offset_value;
      end else if ((state == st_issue) && write_done) begin
        offset <= (next_offset >= region_end && mode == mode_wrap) ? '0 : next_offset;
      end
      case (state)
        st_idle: begin
          if (fifo_valid && fifo_ready) begin
            state   <= st_issue;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end
        end
        st_issue: begin
          if (aw_hs) aw_done <= 1'b1;
          if (w_hs) w_done <= 1'b1;
          if (write_done) begin
            if ((mode == mode_stop) && (next_offset >= region_end) && !offset_load) begin
              state    <= st_stopped;
              full_set <= 1'b1; // last beat of the region has landed.
            end else begin
              state <= st_idle;
            end
          end
        end
        st_stopped: begin
          if (offset_load && !full) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* verilog/trace_dma.sv */
`timescale 1ns/100ps

module trace_dma
  import trace_dma_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ctrl_wen,
  input  logic [ctrl_addr_width-1:0] ctrl_waddr,
  input  logic [31:0]                ctrl_wdata,
  input  logic                       ctrl_ren,
  input  logic [ctrl_addr_width-1:0] ctrl_raddr,
  output logic [31:0]                ctrl_rdata,
  input  logic                       trace_valid,
  input  logic [data_width-1:0]      trace_data,
  output logic                       trace_ready,
  output logic                       trace_full,
  output logic [addr_width-1:0]      m_axi_awaddr,
  output logic                       m_axi_awvalid,
  input  logic                       m_axi_awready,
  output logic [data_width-1:0]      m_axi_wdata,
  output logic                       m_axi_wvalid,
  input  logic                       m_axi_wready,
  input  logic [1:0]                 m_axi_bresp,
  input  logic                       m_axi_bvalid
);

  write_mode_e           mode;
  logic [addr_width-1:0] base_addr;
  logic [3:0]            size_field;
  logic                  offset_load;
  logic [31:0]           offset_value;
  logic [31:0]           write_offset;
  logic                  full_set;
  logic                  resp_error;
  logic                  fifo_valid;
  logic [data_width-1:0] fifo_data;
  logic                  fifo_ready;

  trace_regs i_regs (
    .clk, .rst, .ctrl_wen, .ctrl_waddr, .ctrl_wdata, .ctrl_ren, .ctrl_raddr, .ctrl_rdata,
    .write_offset, .full_set, .resp_error, .mode, .base_addr, .size_field,
    .offset_load, .offset_value, .full(trace_full)
  );

  trace_fifo i_fifo (
    .clk, .rst, .in_valid(trace_valid), .in_data(trace_data), .in_ready(trace_ready),
    .out_valid(fifo_valid), .out_data(fifo_data), .out_ready(fifo_ready)
  );

  // the full level from the registers keeps the writer parked until software clears it.
  trace_axi_writer i_writer (
    .clk, .rst, .mode, .base_addr, .size_field, .offset_load, .offset_value,
    .full(trace_full), .fifo_valid, .fifo_data, .fifo_ready,
    .m_axi_awaddr, .m_axi_awvalid, .m_axi_awready, .m_axi_wdata, .m_axi_wvalid,
    .m_axi_wready, .m_axi_bresp, .m_axi_bvalid, .write_offset, .full_set, .resp_error
  );

endmodule

/* verilog/trace_dma_pkg.sv */
package trace_dma_pkg;

  // bus and data widths.
  localparam int addr_width      = 36;
  localparam int data_width      = 64;
  localparam int beat_bytes      = 8;
  localparam int ctrl_addr_width = 12;

  // region size in bytes is region_unit shifted left by the 4-bit size field.
  localparam int region_unit = 64;

  localparam int fifo_depth     = 8;
  localparam int fifo_ptr_width = 3;

  // register byte offsets on the control port.
  localparam logic [ctrl_addr_width-1:0] reg_mode    = 12'd0;
  localparam logic [ctrl_addr_width-1:0] reg_base_lo = 12'd4;
  localparam logic [ctrl_addr_width-1:0] reg_base_hi = 12'd8;
  localparam logic [ctrl_addr_width-1:0] reg_size    = 12'd12;
  localparam logic [ctrl_addr_width-1:0] reg_offset  = 12'd16;
  localparam logic [ctrl_addr_width-1:0] reg_full    = 12'd20;
  localparam logic [ctrl_addr_width-1:0] reg_errors  = 12'd24;

  localparam logic [1:0] axi_resp_okay = 2'd0;

  typedef enum logic [1:0] {
    mode_stop = 2'd0, // capture halts at the region end.
    mode_wrap = 2'd1  // offset returns to zero at the region end.
  } write_mode_e;

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_stopped
  } writer_state_e;

endpackage

/* verilog/trace_fifo.sv */
`timescale 1ns/100ps

module trace_fifo
  import trace_dma_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  logic [data_width-1:0] in_data,
  output logic                  in_ready,
  output logic                  out_valid,
  output logic [data_width-1:0] out_data,
  input  logic                  out_ready
);

  logic [data_width-1:0]     mem [fifo_depth];
  logic [fifo_ptr_width-1:0] wr_ptr;
  logic [fifo_ptr_width-1:0] rd_ptr;
  logic [fifo_ptr_width:0]   count;
  logic                      push;
  logic                      pop;

  // a full FIFO still takes a word when the head leaves in the same cycle.
  assign in_ready  = (count != (fifo_ptr_width + 1)'(fifo_depth)) || out_ready;
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr]; // first word falls through.

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

/* verilog/trace_regs.sv */
`timescale 1ns/100ps

module trace_regs
  import trace_dma_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ctrl_wen,
  input  logic [ctrl_addr_width-1:0] ctrl_waddr,
  input  logic [31:0]                ctrl_wdata,
  input  logic                       ctrl_ren,
  input  logic [ctrl_addr_width-1:0] ctrl_raddr,
  output logic [31:0]                ctrl_rdata,
  input  logic [31:0]                write_offset,
  input  logic                       full_set,
  input  logic                       resp_error,
  output write_mode_e                mode,
  output logic [addr_width-1:0]      base_addr,
  output logic [3:0]                 size_field,
  output logic                       offset_load,
  output logic [31:0]                offset_value,
  output logic                       full
);

  logic [15:0] err_count;

  // the writer loads the offset on the same edge that the write lands here.
  assign offset_load  = ctrl_wen && (ctrl_waddr == reg_offset);
  assign offset_value = ctrl_wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      mode       <= mode_stop;
      base_addr  <= '0;
      size_field <= '0;
    end else if (ctrl_wen) begin
      case (ctrl_waddr)
        reg_mode:    mode <= write_mode_e'(ctrl_wdata[1:0]);
        reg_base_lo: base_addr[31:0] <= ctrl_wdata;
        reg_base_hi: base_addr[addr_width-1:32] <= ctrl_wdata[addr_width-33:0];
        reg_size:    size_field <= ctrl_wdata[3:0];
        default: ;
      endcase
    end
  end

  // software write has priority over the set strobe from the writer.
  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (ctrl_wen && (ctrl_waddr == reg_full)) begin
      full <= ctrl_wdata[0];
    end else if (full_set) begin
      full <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      err_count <= '0;
    end else if (ctrl_wen && (ctrl_waddr == reg_errors)) begin
      err_count <= '0;
    end else if (resp_error && (err_count != 16'hffff)) begin
      err_count <= err_count + 16'd1; // saturates at all ones.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_rdata <= '0;
    end else if (ctrl_ren) begin
      case (ctrl_raddr)
        reg_mode:    ctrl_rdata <= {30'd0, mode};
        reg_base_lo: ctrl_rdata <= base_addr[31:0];
        reg_base_hi: ctrl_rdata <= {{(64 - addr_width){1'b0}}, base_addr[addr_width-1:32]};
        reg_size:    ctrl_rdata <= {28'd0, size_field};
        reg_offset:  ctrl_rdata <= write_offset;
        reg_full:    ctrl_rdata <= {31'd0, full};
        reg_errors:  ctrl_rdata <= {16'd0, err_count};
        default:     ctrl_rdata <= '0;
      endcase
    end
  end

endmodule
